// ==== test/cce_trace.hex ====
// First word: program length, followed by one microcode word per line
// Then records: request addr, request lce, command addr, command lce, command type
00000009
4b000001 // 0: r2 = r3 + 1, mask for address bit 0
80000000 // 1: pop request into r0
34800000 // 2: r1 = r0 & r2
61e00007 // 3: bne r1, r3 to 7, predicted taken
40000004 // 4: r0 = r0 + 4
90080000 // 5: push set_tag at r0
70000001 // 6: bi 1
90000000 // 7: push inv at r0
70000001 // 8: bi 1
1230 3 1234 3 1
0457 5 0457 5 0
fffe 0 0002 0 1
8001 f 8001 f 0
00a4 2 00a8 2 1
3c3d 9 3c3d 9 0
7ff9 6 7ff9 6 0
0100 c 0104 c 1

// ==== files.f ====
logic/cce_isa_pkg.sv
logic/cce_msg_pkg.sv
logic/cce_fetch.sv
logic/cce_inst_decode.sv
logic/cce_execute.sv
logic/cce_reg.sv
logic/cce_msg.sv
logic/cce_top.sv
test/tb_cce.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the CCE testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --timescale 1ns/1ps -f files.f --top-module tb_cce \
  -Mdir "$build_dir" -o sim_cce
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$build_dir/sim_cce" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "All tests passed" "$log_file"; then
  exit 0
fi
echo "Pass message not found in $log_file"
exit 1

// ==== test/tb_cce.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cce;

  localparam int ucode_depth_lp = 64;
  localparam int pc_width_lp = $clog2(ucode_depth_lp);
  localparam int clk_period_lp = 20;
  localparam int sample_delay_lp = 5;
  localparam int reset_cycles_lp = 5;
  localparam int num_records_lp = 8;
  localparam int rec_words_lp = 5;
  localparam int trace_depth_lp = 64;
  localparam int timeout_cycles_lp = num_records_lp * 200;
  localparam int idle_cycles_lp = 10;
  localparam int hold_cycles_lp = 60;
  localparam int quiet_cycles_lp = 30;
  // Commands sent before ready is held low, and pops that still fit while it is low
  localparam int hold_first_lp = 5;
  localparam int hold_pops_lp = 2;

  logic                    clk_i;
  logic                    rst_i;
  logic                    cfg_ucode_w_v_i;
  logic [pc_width_lp-1:0]  cfg_ucode_addr_i;
  cce_isa_pkg::cce_inst_t  cfg_ucode_data_i;
  logic                    cfg_run_i;
  logic                    lce_req_v_i;
  cce_msg_pkg::paddr_t     lce_req_addr_i;
  cce_msg_pkg::lce_id_t    lce_req_lce_i;
  logic                    lce_req_yumi_o;
  logic                    lce_cmd_v_o;
  logic                    lce_cmd_ready_i;
  cce_msg_pkg::paddr_t     lce_cmd_addr_o;
  cce_msg_pkg::lce_id_t    lce_cmd_lce_o;
  cce_msg_pkg::cmd_type_e  lce_cmd_type_o;

  logic [31:0]             trace_mem [trace_depth_lp];
  integer                  seed = 32'h58aa;
  string                   current_test;
  int                      rec_base;
  int                      req_idx;
  int                      req_limit;
  int                      gap_left;
  int                      cmd_count;
  int                      yumi_count;
  int                      even_seen;
  int                      odd_seen;
  int                      test_errors;
  int                      errors;
  int                      tests_run;
  int                      tests_failed;
  bit                      req_pending;
  bit                      ready_low;
  bit                      allow_gaps;
  bit                      run_enable;
  bit                      held_v;
  cce_msg_pkg::paddr_t     held_addr;
  cce_msg_pkg::lce_id_t    held_lce;
  cce_msg_pkg::cmd_type_e  held_type;

  cce_top #(.ucode_depth_p(ucode_depth_lp)) dut_i
    (.clk_i(clk_i), .rst_i(rst_i)
     , .cfg_ucode_w_v_i(cfg_ucode_w_v_i), .cfg_ucode_addr_i(cfg_ucode_addr_i)
     , .cfg_ucode_data_i(cfg_ucode_data_i), .cfg_run_i(cfg_run_i)
     , .lce_req_v_i(lce_req_v_i), .lce_req_addr_i(lce_req_addr_i)
     , .lce_req_lce_i(lce_req_lce_i), .lce_req_yumi_o(lce_req_yumi_o)
     , .lce_cmd_v_o(lce_cmd_v_o), .lce_cmd_ready_i(lce_cmd_ready_i)
     , .lce_cmd_addr_o(lce_cmd_addr_o), .lce_cmd_lce_o(lce_cmd_lce_o)
     , .lce_cmd_type_o(lce_cmd_type_o)
     );

  initial begin
    clk_i = 1'b0;
    forever #(clk_period_lp / 2) clk_i = ~clk_i;
  end

  // Watchdog sized from the record count
  initial begin
    #(timeout_cycles_lp * clk_period_lp);
    $display("Timeout: run still busy after %0d cycles in test %s", timeout_cycles_lp,
             current_test);
    $display("Some tests failed");
    $finish;
  end

  function automatic logic [31:0] trace_word(input int idx);
    return trace_mem[idx[$clog2(trace_depth_lp)-1:0]];
  endfunction

  function automatic logic [31:0] rec_field(input int rec, input int field);
    return trace_word(rec_base + rec * rec_words_lp + field);
  endfunction

  task automatic value_error(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    $display("[ERROR] %s: expected 0x%h, got 0x%h at %0t", name, exp, got, $time);
    test_errors++;
  endtask

  task automatic check_failed(input string msg);
    $display("Failure at %0t: %s", $time, msg);
    test_errors++;
  endtask

  task automatic begin_test(input string name);
    current_test = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    tests_run++;
    if (test_errors == 0) begin
      $display("Test %s: passed", current_test);
    end else begin
      $display("Test %s: failed with %0d errors", current_test, test_errors);
      tests_failed++;
      errors += test_errors;
    end
  endtask

  task automatic load_program();
    int prog_len;
    $readmemh("test/cce_trace.hex", trace_mem);
    prog_len = trace_word(0);
    rec_base = 1 + prog_len;
    if (prog_len < 1 || prog_len > ucode_depth_lp) begin
      check_failed($sformatf("program length %0d does not fit the microcode RAM", prog_len));
    end else begin
      for (int i = 0; i < prog_len; i++) begin
        @(negedge clk_i);
        cfg_ucode_w_v_i = 1'b1;
        cfg_ucode_addr_i = i[pc_width_lp-1:0];
        cfg_ucode_data_i = trace_word(1 + i);
      end
      @(negedge clk_i);
      cfg_ucode_w_v_i = 1'b0;
    end
    if (rec_base + num_records_lp * rec_words_lp > trace_depth_lp) begin
      check_failed("trace records run past the end of the trace memory");
    end
  endtask

  task automatic check_trace_rules();
    logic [31:0] req_addr;
    logic [31:0] req_lce;
    logic [31:0] cmd_addr;
    logic [31:0] cmd_lce;
    logic [31:0] cmd_type;
    logic [15:0] rule_addr;
    logic [1:0]  rule_type;
    for (int i = 0; i < num_records_lp; i++) begin
      req_addr = rec_field(i, 0);
      req_lce = rec_field(i, 1);
      cmd_addr = rec_field(i, 2);
      cmd_lce = rec_field(i, 3);
      cmd_type = rec_field(i, 4);
      // Odd addresses invalidate in place, even ones set the tag at address plus 4
      if (req_addr[0]) begin
        rule_addr = req_addr[15:0];
        rule_type = cce_msg_pkg::cmd_inv;
      end else begin
        rule_addr = req_addr[15:0] + 16'd4;
        rule_type = cce_msg_pkg::cmd_set_tag;
      end
      if (cmd_addr[15:0] !== rule_addr || cmd_lce[3:0] !== req_lce[3:0]
          || cmd_type[1:0] !== rule_type) begin
        check_failed($sformatf("trace record %0d breaks the request to command mapping", i));
      end
    end
  endtask

  task automatic drive_request();
    logic [31:0] word;
    if (!req_pending) begin
      if (gap_left > 0) begin
        gap_left--;
        lce_req_v_i = 1'b0;
      end else if (req_idx < req_limit) begin
        word = rec_field(req_idx, 0);
        lce_req_addr_i = word[15:0];
        word = rec_field(req_idx, 1);
        lce_req_lce_i = word[3:0];
        lce_req_v_i = 1'b1;
        req_pending = 1'b1;
      end else begin
        lce_req_v_i = 1'b0;
      end
    end
  endtask

  task automatic compare_command(input int rec);
    logic [31:0] exp_addr;
    logic [31:0] exp_lce;
    logic [31:0] exp_type;
    exp_addr = rec_field(rec, 2);
    exp_lce = rec_field(rec, 3);
    exp_type = rec_field(rec, 4);
    if (lce_cmd_addr_o !== exp_addr[15:0]) begin
      value_error("lce_cmd_addr_o", 32'(lce_cmd_addr_o), exp_addr);
    end
    if (lce_cmd_lce_o !== exp_lce[3:0]) begin
      value_error("lce_cmd_lce_o", 32'(lce_cmd_lce_o), exp_lce);
    end
    if (lce_cmd_type_o !== exp_type[1:0]) begin
      value_error("lce_cmd_type_o", 32'(lce_cmd_type_o), exp_type);
    end
    // Outcome as sent by the DUT, set_tag only after a mispredicted branch
    if (lce_cmd_type_o === cce_msg_pkg::cmd_set_tag) begin
      even_seen++;
    end else if (lce_cmd_type_o === cce_msg_pkg::cmd_inv) begin
      odd_seen++;
    end
  endtask

  task automatic check_cycle();
    if (!cfg_run_i && (lce_req_yumi_o || lce_cmd_v_o)) begin
      check_failed("engine active before cfg_run_i was set");
    end
    if (lce_req_yumi_o && !lce_req_v_i) begin
      check_failed("lce_req_yumi_o raised without lce_req_v_i");
    end else if (lce_req_yumi_o) begin
      if (ready_low && req_idx - hold_first_lp >= hold_pops_lp) begin
        check_failed($sformatf("request %0d popped behind a stalled push", req_idx));
      end
      yumi_count++;
      req_idx++;
      req_pending = 1'b0;
      gap_left = allow_gaps ? ($random(seed) & 32'h3) : 0;
    end
    // A command waiting on ready must hold still
    if (held_v && !lce_cmd_v_o) begin
      check_failed("command withdrawn while lce_cmd_ready_i was low");
    end else if (held_v) begin
      if (lce_cmd_addr_o !== held_addr) begin
        value_error("lce_cmd_addr_o", 32'(lce_cmd_addr_o), 32'(held_addr));
      end
      if (lce_cmd_lce_o !== held_lce) begin
        value_error("lce_cmd_lce_o", 32'(lce_cmd_lce_o), 32'(held_lce));
      end
      if (lce_cmd_type_o !== held_type) begin
        value_error("lce_cmd_type_o", 32'(lce_cmd_type_o), 32'(held_type));
      end
    end
    if (lce_cmd_v_o && lce_cmd_ready_i) begin
      if (cmd_count >= num_records_lp) begin
        check_failed("command received after the last trace record");
      end else begin
        compare_command(cmd_count);
      end
      cmd_count++;
    end
    held_v = lce_cmd_v_o && !lce_cmd_ready_i;
    held_addr = lce_cmd_addr_o;
    held_lce = lce_cmd_lce_o;
    held_type = lce_cmd_type_o;
  endtask

  // Drive on the falling edge, sample before the next rising edge
  task automatic run_cycle();
    @(negedge clk_i);
    cfg_run_i = run_enable;
    drive_request();
    if (ready_low) begin
      lce_cmd_ready_i = 1'b0;
    end else begin
      lce_cmd_ready_i = (($random(seed) & 32'h3) != 0);
    end
    #(sample_delay_lp);
    check_cycle();
  endtask

  initial begin
    rst_i = 1'b1;
    cfg_ucode_w_v_i = 1'b0;
    cfg_ucode_addr_i = '0;
    cfg_ucode_data_i = '0;
    cfg_run_i = 1'b0;
    lce_req_v_i = 1'b0;
    lce_req_addr_i = '0;
    lce_req_lce_i = '0;
    lce_cmd_ready_i = 1'b0;
    run_enable = 1'b0;
    current_test = "reset";
    repeat (reset_cycles_lp) @(negedge clk_i);
    rst_i = 1'b0;

    begin_test("load_program");
    load_program();
    check_trace_rules();
    end_test();

    begin_test("idle_before_run");
    req_limit = 1;
    repeat (idle_cycles_lp) run_cycle();
    end_test();

    begin_test("command_mapping");
    run_enable = 1'b1;
    allow_gaps = 1'b1;
    req_limit = hold_first_lp;
    while (cmd_count < hold_first_lp) run_cycle();
    end_test();

    begin_test("back_pressure");
    ready_low = 1'b1;
    allow_gaps = 1'b0;
    req_limit = num_records_lp;
    while (req_idx < hold_first_lp + hold_pops_lp) run_cycle();
    repeat (hold_cycles_lp) run_cycle();
    if (!lce_cmd_v_o) begin
      check_failed("no command pending while lce_cmd_ready_i was held low");
    end
    if (req_idx != hold_first_lp + hold_pops_lp) begin
      check_failed($sformatf("%0d requests popped under back-pressure instead of %0d",
                             req_idx - hold_first_lp, hold_pops_lp));
    end
    end_test();

    begin_test("drain_and_branches");
    ready_low = 1'b0;
    allow_gaps = 1'b1;
    while (cmd_count < num_records_lp) run_cycle();
    if (even_seen == 0 || odd_seen == 0) begin
      check_failed("commands did not show both branch outcomes");
    end
    end_test();

    begin_test("handshake_totals");
    repeat (quiet_cycles_lp) run_cycle();
    if (yumi_count != cmd_count) begin
      check_failed($sformatf("%0d requests popped but %0d commands received",
                             yumi_count, cmd_count));
    end
    end_test();

    $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors", tests_run,
             tests_run - tests_failed, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== logic/cce_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cce_top
  #(parameter int ucode_depth_p = 64
    , localparam int pc_width_lp = $clog2(ucode_depth_p)
    )
  (input logic                          clk_i
   , input logic                        rst_i
   // Configuration
   , input logic                        cfg_ucode_w_v_i
   , input logic [pc_width_lp-1:0]      cfg_ucode_addr_i
   , input cce_isa_pkg::cce_inst_t      cfg_ucode_data_i
   , input logic                        cfg_run_i
   // LCE request, valid then yumi
   , input logic                        lce_req_v_i
   , input cce_msg_pkg::paddr_t         lce_req_addr_i
   , input cce_msg_pkg::lce_id_t        lce_req_lce_i
   , output logic                       lce_req_yumi_o
   // LCE command, ready then valid
   , output logic                       lce_cmd_v_o
   , input logic                        lce_cmd_ready_i
   , output cce_msg_pkg::paddr_t        lce_cmd_addr_o
   , output cce_msg_pkg::lce_id_t       lce_cmd_lce_o
   , output cce_msg_pkg::cmd_type_e     lce_cmd_type_o
   );

  // Fetch to decode
  cce_isa_pkg::cce_inst_t  fetch_inst;
  logic                    fetch_inst_v;
  logic [pc_width_lp-1:0]  fetch_pc;

  // Decode to execute stage
  cce_isa_pkg::opcode_e    dec_opcode;
  cce_isa_pkg::gpr_sel_t   dec_dst, dec_src_a, dec_src_b;
  cce_isa_pkg::gpr_t       dec_imm;
  logic                    dec_predict_taken;
  cce_msg_pkg::cmd_type_e  dec_cmd_type;
  logic [pc_width_lp-1:0]  ex_pc;

  // Execute, registers and message unit
  cce_isa_pkg::gpr_t       alu_res, src_a_val, src_b_val;
  logic                    mispredict, stall, pop_w_v;
  logic [pc_width_lp-1:0]  redirect_pc;
  cce_msg_pkg::lce_id_t    req_lce, pop_lce;
  cce_msg_pkg::paddr_t     pop_addr;

  cce_fetch #(.ucode_depth_p(ucode_depth_p)) fetch
    (.clk_i(clk_i), .rst_i(rst_i)
     , .cfg_ucode_w_v_i(cfg_ucode_w_v_i), .cfg_ucode_addr_i(cfg_ucode_addr_i)
     , .cfg_ucode_data_i(cfg_ucode_data_i), .cfg_run_i(cfg_run_i)
     , .stall_i(stall), .mispredict_i(mispredict), .redirect_pc_i(redirect_pc)
     , .inst_o(fetch_inst), .inst_v_o(fetch_inst_v), .pc_o(fetch_pc)
     );

  cce_inst_decode #(.ucode_depth_p(ucode_depth_p)) inst_decode
    (.clk_i(clk_i), .rst_i(rst_i)
     , .inst_i(fetch_inst), .inst_v_i(fetch_inst_v), .pc_i(fetch_pc)
     , .stall_i(stall), .mispredict_i(mispredict)
     , .opcode_o(dec_opcode), .dst_o(dec_dst), .src_a_o(dec_src_a), .src_b_o(dec_src_b)
     , .imm_o(dec_imm), .predict_taken_o(dec_predict_taken)
     , .cmd_type_o(dec_cmd_type), .pc_o(ex_pc)
     );

  cce_execute #(.ucode_depth_p(ucode_depth_p)) execute
    (.opcode_i(dec_opcode), .src_a_val_i(src_a_val), .src_b_val_i(src_b_val)
     , .imm_i(dec_imm), .predict_taken_i(dec_predict_taken), .pc_i(ex_pc)
     , .alu_res_o(alu_res), .mispredict_o(mispredict), .redirect_pc_o(redirect_pc)
     );

  cce_reg registers
    (.clk_i(clk_i), .rst_i(rst_i), .stall_i(stall), .opcode_i(dec_opcode)
     , .dst_i(dec_dst), .src_a_i(dec_src_a), .src_b_i(dec_src_b), .alu_res_i(alu_res)
     , .pop_w_v_i(pop_w_v), .pop_addr_i(pop_addr), .pop_lce_i(pop_lce)
     , .src_a_val_o(src_a_val), .src_b_val_o(src_b_val), .req_lce_o(req_lce)
     );

  cce_msg message
    (.clk_i(clk_i), .rst_i(rst_i)
     , .opcode_i(dec_opcode), .cmd_type_i(dec_cmd_type)
     , .src_a_val_i(src_a_val), .req_lce_i(req_lce)
     , .lce_req_v_i(lce_req_v_i), .lce_req_addr_i(lce_req_addr_i)
     , .lce_req_lce_i(lce_req_lce_i), .lce_cmd_ready_i(lce_cmd_ready_i)
     , .lce_req_yumi_o(lce_req_yumi_o), .pop_w_v_o(pop_w_v)
     , .pop_addr_o(pop_addr), .pop_lce_o(pop_lce), .stall_o(stall)
     , .lce_cmd_v_o(lce_cmd_v_o), .lce_cmd_addr_o(lce_cmd_addr_o)
     , .lce_cmd_lce_o(lce_cmd_lce_o), .lce_cmd_type_o(lce_cmd_type_o)
     );

endmodule

`default_nettype wire

// ==== logic/cce_msg.sv ====
`timescale 1ns/1ps
`default_nettype none

module cce_msg
  (input logic                          clk_i
   , input logic                        rst_i
   , input cce_isa_pkg::opcode_e        opcode_i
   , input cce_msg_pkg::cmd_type_e      cmd_type_i
   , input cce_isa_pkg::gpr_t           src_a_val_i
   , input cce_msg_pkg::lce_id_t        req_lce_i
   , input logic                        lce_req_v_i
   , input cce_msg_pkg::paddr_t         lce_req_addr_i
   , input cce_msg_pkg::lce_id_t        lce_req_lce_i
   , input logic                        lce_cmd_ready_i
   , output logic                       lce_req_yumi_o
   , output logic                       pop_w_v_o
   , output cce_msg_pkg::paddr_t        pop_addr_o
   , output cce_msg_pkg::lce_id_t       pop_lce_o
   , output logic                       stall_o
   , output logic                       lce_cmd_v_o
   , output cce_msg_pkg::paddr_t        lce_cmd_addr_o
   , output cce_msg_pkg::lce_id_t       lce_cmd_lce_o
   , output cce_msg_pkg::cmd_type_e     lce_cmd_type_o
   );

  logic is_pop;
  logic is_push;
  logic cmd_drain;
  logic cmd_blocked;
  logic push_v;

  assign is_pop  = (opcode_i == cce_isa_pkg::op_popq);
  assign is_push = (opcode_i == cce_isa_pkg::op_pushq);

  // Request side, consumed in the cycle the pop executes
  assign lce_req_yumi_o = is_pop & lce_req_v_i;
  assign pop_w_v_o      = is_pop & lce_req_v_i;
  assign pop_addr_o     = lce_req_addr_i;
  assign pop_lce_o      = lce_req_lce_i;

  // Command slot frees up in the same cycle it drains
  assign cmd_drain   = lce_cmd_v_o & lce_cmd_ready_i;
  assign cmd_blocked = lce_cmd_v_o & ~lce_cmd_ready_i;
  assign push_v      = is_push & ~cmd_blocked;

  assign stall_o = (is_pop & ~lce_req_v_i) | (is_push & cmd_blocked);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      lce_cmd_v_o <= 1'b0;
    end else if (push_v) begin
      lce_cmd_v_o <= 1'b1;
    end else if (cmd_drain) begin
      lce_cmd_v_o <= 1'b0;
    end
  end

  // Command fields
  always_ff @(posedge clk_i) begin
    if (push_v) begin
      lce_cmd_addr_o <= src_a_val_i;
      lce_cmd_lce_o  <= req_lce_i;
      lce_cmd_type_o <= cmd_type_i;
    end
  end

endmodule

`default_nettype wire

// ==== logic/cce_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module cce_reg
  (input logic                          clk_i
   , input logic                        rst_i
   , input logic                        stall_i
   , input cce_isa_pkg::opcode_e        opcode_i
   , input cce_isa_pkg::gpr_sel_t       dst_i
   , input cce_isa_pkg::gpr_sel_t       src_a_i
   , input cce_isa_pkg::gpr_sel_t       src_b_i
   , input cce_isa_pkg::gpr_t           alu_res_i
   , input logic                        pop_w_v_i
   , input cce_msg_pkg::paddr_t         pop_addr_i
   , input cce_msg_pkg::lce_id_t        pop_lce_i
   , output cce_isa_pkg::gpr_t          src_a_val_o
   , output cce_isa_pkg::gpr_t          src_b_val_o
   , output cce_msg_pkg::lce_id_t       req_lce_o
   );

  cce_isa_pkg::gpr_t    gpr_r [cce_isa_pkg::num_gpr];
  cce_msg_pkg::lce_id_t req_lce_r;
  logic                 alu_w_v;

  assign alu_w_v = !stall_i && (opcode_i inside {cce_isa_pkg::op_add, cce_isa_pkg::op_sub,
                                                 cce_isa_pkg::op_and, cce_isa_pkg::op_addi});

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < cce_isa_pkg::num_gpr; i++) begin
        gpr_r[i] <= '0;
      end
      req_lce_r <= '0;
    end else if (pop_w_v_i) begin
      // Request address to dst, requester kept for the reply
      gpr_r[dst_i] <= pop_addr_i;
      req_lce_r    <= pop_lce_i;
    end else if (alu_w_v) begin
      gpr_r[dst_i] <= alu_res_i;
    end
  end

  assign src_a_val_o = gpr_r[src_a_i];
  assign src_b_val_o = gpr_r[src_b_i];
  assign req_lce_o   = req_lce_r;

endmodule

`default_nettype wire

// ==== logic/cce_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module cce_execute
  #(parameter int ucode_depth_p = 64
    , localparam int pc_width_lp = $clog2(ucode_depth_p)
    )
  (input cce_isa_pkg::opcode_e          opcode_i
   , input cce_isa_pkg::gpr_t           src_a_val_i
   , input cce_isa_pkg::gpr_t           src_b_val_i
   , input cce_isa_pkg::gpr_t           imm_i
   , input logic                        predict_taken_i
   , input logic [pc_width_lp-1:0]      pc_i
   , output cce_isa_pkg::gpr_t          alu_res_o
   , output logic                       mispredict_o
   , output logic [pc_width_lp-1:0]     redirect_pc_o
   );

  logic is_branch;
  logic taken;
  logic predicted;

  // ALU
  always_comb begin
    case (opcode_i)
      cce_isa_pkg::op_add:  alu_res_o = src_a_val_i + src_b_val_i;
      cce_isa_pkg::op_sub:  alu_res_o = src_a_val_i - src_b_val_i;
      cce_isa_pkg::op_and:  alu_res_o = src_a_val_i & src_b_val_i;
      cce_isa_pkg::op_addi: alu_res_o = src_a_val_i + imm_i;
      default:              alu_res_o = '0;
    endcase
  end

  // Branch resolution
  always_comb begin
    is_branch = 1'b1;
    case (opcode_i)
      cce_isa_pkg::op_beq: taken = (src_a_val_i == src_b_val_i);
      cce_isa_pkg::op_bne: taken = (src_a_val_i != src_b_val_i);
      cce_isa_pkg::op_bi:  taken = 1'b1;
      default: begin
        is_branch = 1'b0;
        taken     = 1'b0;
      end
    endcase
  end

  // Fetch always follows op_bi, so only its prediction is implied
  assign predicted = (opcode_i == cce_isa_pkg::op_bi) ? 1'b1 : predict_taken_i;

  assign mispredict_o  = is_branch & (taken != predicted);
  assign redirect_pc_o = taken ? imm_i[pc_width_lp-1:0] : pc_i + 1'b1;

endmodule

`default_nettype wire

// ==== logic/cce_inst_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module cce_inst_decode
  #(parameter int ucode_depth_p = 64
    , localparam int pc_width_lp = $clog2(ucode_depth_p)
    )
  (input logic                          clk_i
   , input logic                        rst_i
   , input cce_isa_pkg::cce_inst_t      inst_i
   , input logic                        inst_v_i
   , input logic [pc_width_lp-1:0]      pc_i
   , input logic                        stall_i
   , input logic                        mispredict_i
   , output cce_isa_pkg::opcode_e       opcode_o
   , output cce_isa_pkg::gpr_sel_t      dst_o
   , output cce_isa_pkg::gpr_sel_t      src_a_o
   , output cce_isa_pkg::gpr_sel_t      src_b_o
   , output cce_isa_pkg::gpr_t          imm_o
   , output logic                       predict_taken_o
   , output cce_msg_pkg::cmd_type_e     cmd_type_o
   , output logic [pc_width_lp-1:0]     pc_o
   );

  localparam int sel_width_lp = $bits(cce_isa_pkg::gpr_sel_t);

  // Opcode and prediction bit, flushed to a nop on mispredict or empty fetch
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      opcode_o        <= cce_isa_pkg::op_nop;
      predict_taken_o <= 1'b0;
    end else if (mispredict_i || (!stall_i && !inst_v_i)) begin
      opcode_o        <= cce_isa_pkg::op_nop;
      predict_taken_o <= 1'b0;
    end else if (!stall_i) begin
      opcode_o <= cce_isa_pkg::opcode_e'(
        inst_i[cce_isa_pkg::opcode_lsb +: cce_isa_pkg::opcode_width]);
      predict_taken_o <= inst_i[cce_isa_pkg::predict_taken_bit];
    end
  end

  // Operand fields only matter under a live opcode
  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      dst_o      <= inst_i[cce_isa_pkg::dst_lsb +: sel_width_lp];
      src_a_o    <= inst_i[cce_isa_pkg::src_a_lsb +: sel_width_lp];
      src_b_o    <= inst_i[cce_isa_pkg::src_b_lsb +: sel_width_lp];
      imm_o      <= inst_i[cce_isa_pkg::imm_lsb +: cce_isa_pkg::gpr_width];
      cmd_type_o <= cce_msg_pkg::cmd_type_e'(
        inst_i[cce_isa_pkg::cmd_type_lsb +: $bits(cce_msg_pkg::cmd_type_e)]);
      pc_o       <= pc_i;
    end
  end

endmodule

`default_nettype wire

// ==== logic/cce_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

module cce_fetch
  #(parameter int ucode_depth_p = 64
    , localparam int pc_width_lp = $clog2(ucode_depth_p)
    )
  (input logic                        clk_i
   , input logic                      rst_i
   , input logic                      cfg_ucode_w_v_i
   , input logic [pc_width_lp-1:0]    cfg_ucode_addr_i
   , input cce_isa_pkg::cce_inst_t    cfg_ucode_data_i
   , input logic                      cfg_run_i
   , input logic                      stall_i
   , input logic                      mispredict_i
   , input logic [pc_width_lp-1:0]    redirect_pc_i
   , output cce_isa_pkg::cce_inst_t   inst_o
   , output logic                     inst_v_o
   , output logic [pc_width_lp-1:0]   pc_o
   );

  cce_isa_pkg::cce_inst_t ucode_mem [ucode_depth_p];
  cce_isa_pkg::cce_inst_t inst_r;
  cce_isa_pkg::opcode_e   pre_opcode;
  logic                   run_r;
  logic                   inst_v_r;
  logic                   pre_taken;
  logic [pc_width_lp-1:0] pc_r;
  logic [pc_width_lp-1:0] predict_pc;
  logic [pc_width_lp-1:0] rd_addr;

  // Predecode of the word at the RAM output
  assign pre_opcode = cce_isa_pkg::opcode_e'(
    inst_r[cce_isa_pkg::opcode_lsb +: cce_isa_pkg::opcode_width]);

  always_comb begin
    case (pre_opcode)
      cce_isa_pkg::op_bi: pre_taken = 1'b1;
      cce_isa_pkg::op_beq, cce_isa_pkg::op_bne: begin
        pre_taken = inst_r[cce_isa_pkg::predict_taken_bit];
      end
      default: pre_taken = 1'b0;
    endcase
  end

  assign predict_pc = pre_taken ? inst_r[cce_isa_pkg::imm_lsb +: pc_width_lp] : pc_r + 1'b1;

  // Re-read pc_r while idle, refilling or stalled
  // The redirect PC is registered first, keeping execute off the RAM address path
  assign rd_addr = (run_r && inst_v_r && !stall_i) ? predict_pc : pc_r;

  // Microcode RAM, written only while stopped
  always_ff @(posedge clk_i) begin
    if (cfg_ucode_w_v_i && !cfg_run_i) begin
      ucode_mem[cfg_ucode_addr_i] <= cfg_ucode_data_i;
    end
    inst_r <= ucode_mem[rd_addr];
  end

  // pc_r always tracks the PC of the word in inst_r
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      run_r    <= 1'b0;
      inst_v_r <= 1'b0;
      pc_r     <= '0;
    end else begin
      run_r <= cfg_run_i;
      if (!run_r) begin
        inst_v_r <= 1'b0;
        pc_r     <= '0;
      end else if (mispredict_i) begin
        inst_v_r <= 1'b0;
        pc_r     <= redirect_pc_i;
      end else if (!inst_v_r) begin
        inst_v_r <= 1'b1;
      end else if (!stall_i) begin
        pc_r <= predict_pc;
      end
    end
  end

  assign inst_o   = inst_r;
  assign inst_v_o = inst_v_r & run_r;
  assign pc_o     = pc_r;

endmodule

`default_nettype wire

// ==== logic/cce_msg_pkg.sv ====
`default_nettype none

package cce_msg_pkg;

  // Block address and LCE id widths
  localparam int paddr_width = 16;
  localparam int lce_id_width = 4;

  typedef logic [paddr_width-1:0] paddr_t;
  typedef logic [lce_id_width-1:0] lce_id_t;

  // Command types sent to an LCE
  typedef enum logic [1:0] {
    cmd_inv        = 2'b00
    , cmd_set_tag  = 2'b01
    , cmd_transfer = 2'b10
    , cmd_wb       = 2'b11
  } cmd_type_e;

endpackage

`default_nettype wire

// ==== logic/cce_isa_pkg.sv ====
`default_nettype none

package cce_isa_pkg;

  // Microcode word
  localparam int inst_width = 32;

  // Field positions within a microcode word
  localparam int opcode_width = 4;
  localparam int opcode_lsb = 28;
  localparam int dst_lsb = 26;
  localparam int src_a_lsb = 24;
  localparam int src_b_lsb = 22;
  localparam int predict_taken_bit = 21;
  localparam int cmd_type_lsb = 19;
  // Bits 18:16 are reserved
  localparam int imm_lsb = 0;

  // General purpose registers, as wide as a block address
  localparam int num_gpr = 4;
  localparam int gpr_width = 16;

  typedef logic [inst_width-1:0] cce_inst_t;
  typedef logic [$clog2(num_gpr)-1:0] gpr_sel_t;
  typedef logic [gpr_width-1:0] gpr_t;

  typedef enum logic [opcode_width-1:0] {
    op_nop     = 4'h0
    , op_add   = 4'h1
    , op_sub   = 4'h2
    , op_and   = 4'h3
    // dst = src_a + imm
    , op_addi  = 4'h4
    , op_beq   = 4'h5
    , op_bne   = 4'h6
    // Unconditional branch, always predicted taken
    , op_bi    = 4'h7
    // Pop the LCE request into dst
    , op_popq  = 4'h8
    // Push an LCE command built from src_a
    , op_pushq = 4'h9
  } opcode_e;

endpackage

`default_nettype wire
